/* include/corr_cfg.svh */
`ifndef CORR_CFG_SVH
`define CORR_CFG_SVH

// input samples, one complex value per channel and bin
// signed, DIN_POINT fraction bits
`define DIN_WIDTH 16
`define DIN_POINT 14

// format fed to the accumulators after the cast stage
// products carry 2*DIN_POINT fraction bits before rescale
`define ACC_WIDTH 20
`define ACC_POINT 16

// accumulated result width, integer sums wrap at this size
`define DOUT_WIDTH 32

// frame length in bins
// one sum per bin is kept in each accumulator
`define VECTOR_LEN 8

// pipeline latencies in clock cycles
// multipliers: input register, partial products, final sum
`define MULT_LAT 3
// cast: one output register
`define CAST_LAT 1

`endif

/* verilog/corr_sample_pkg.sv */
`include "corr_cfg.svh"

package corr_sample_pkg;

    // raw input sample of one rail (re or im)
    typedef logic signed [`DIN_WIDTH-1:0] sample_t;

    // fraction bits of a full product
    localparam int PROD_POINT = 2 * `DIN_POINT;

    // sum of two products, one guard bit over a single product
    typedef logic signed [2*`DIN_WIDTH:0] prod_t;

    // rescaled value going into an accumulator
    typedef logic signed [`ACC_WIDTH-1:0] acc_in_t;

    // per-bin accumulated result
    typedef logic signed [`DOUT_WIDTH-1:0] dout_t;

endpackage

/* verilog/corr_acc_pkg.sv */
`include "corr_cfg.svh"

package corr_acc_pkg;

    // accumulator control states
    // idle: nothing integrated yet, samples dropped
    // dump: old sums go out, new samples overwrite
    // run:  samples add into their bins
    typedef enum logic [1:0] {
        acc_idle,
        acc_dump,
        acc_run
    } acc_state_e;

    // position of the current sample inside the frame
    typedef logic [$clog2(`VECTOR_LEN)-1:0] bin_idx_t;

endpackage

/* verilog/correlation_mults.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

module correlation_mults (
    input  logic                      clk,
    input  logic                      rst_n,
    input  corr_sample_pkg::sample_t  din1_re,
    input  corr_sample_pkg::sample_t  din1_im,
    input  corr_sample_pkg::sample_t  din2_re,
    input  corr_sample_pkg::sample_t  din2_im,
    input  logic                      din_valid,
    output corr_sample_pkg::prod_t    pow1,
    output corr_sample_pkg::prod_t    pow2,
    output corr_sample_pkg::prod_t    corr_re,
    output corr_sample_pkg::prod_t    corr_im,
    output logic                      dout_valid
);

    // width of one partial product, 16x16 signed fits in 32
    localparam int PP_W = 2 * `DIN_WIDTH;

    typedef logic signed [PP_W-1:0] pp_t;

    // stage 1, registered inputs
    corr_sample_pkg::sample_t re1_q;
    corr_sample_pkg::sample_t im1_q;
    corr_sample_pkg::sample_t re2_q;
    corr_sample_pkg::sample_t im2_q;

    // stage 2, partial products for the powers
    pp_t re1_sq;
    pp_t im1_sq;
    pp_t re2_sq;
    pp_t im2_sq;

    // stage 2, partial products for x1 * conj(x2)
    pp_t re1_re2;
    pp_t im1_im2;
    pp_t im1_re2;
    pp_t re1_im2;

    // one valid bit per pipeline stage
    logic [`MULT_LAT-1:0] valid_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[`MULT_LAT-2:0], din_valid};
        end
    end

    always_ff @(posedge clk) begin
        re1_q <= din1_re;
        im1_q <= din1_im;
        re2_q <= din2_re;
        im2_q <= din2_im;

        re1_sq   <= re1_q * re1_q;
        im1_sq   <= im1_q * im1_q;
        re2_sq   <= re2_q * re2_q;
        im2_sq   <= im2_q * im2_q;
        re1_re2  <= re1_q * re2_q;
        im1_im2  <= im1_q * im2_q;
        im1_re2  <= im1_q * re2_q;
        re1_im2  <= re1_q * im2_q;

        // |x|^2 = re^2 + im^2
        pow1    <= corr_sample_pkg::prod_t'(re1_sq) + corr_sample_pkg::prod_t'(im1_sq);
        pow2    <= corr_sample_pkg::prod_t'(re2_sq) + corr_sample_pkg::prod_t'(im2_sq);
        // (a+jb)(c-jd) = (ac+bd) + j(bc-ad)
        corr_re <= corr_sample_pkg::prod_t'(re1_re2) + corr_sample_pkg::prod_t'(im1_im2);
        corr_im <= corr_sample_pkg::prod_t'(im1_re2) - corr_sample_pkg::prod_t'(re1_im2);
    end

    assign dout_valid = valid_sr[`MULT_LAT-1];

    // samples flagged valid by the source must be defined
    a_din_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        din_valid |-> !$isunknown({din1_re, din1_im, din2_re, din2_im})
    );

endmodule

/* verilog/fixed_cast.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

module fixed_cast #(
    parameter bit UNSIGNED_OUT = 1'b0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  corr_sample_pkg::prod_t    din,
    input  logic                      din_valid,
    output corr_sample_pkg::acc_in_t  dout,
    output logic                      dout_valid
);

    // fraction bits dropped going to the accumulator format
    localparam int SHIFT = corr_sample_pkg::PROD_POINT - `ACC_POINT;

    // saturation bounds, expressed in the wide product type
    localparam corr_sample_pkg::prod_t MAX_VAL =
        corr_sample_pkg::prod_t'((2 ** (`ACC_WIDTH - 1)) - 1);
    localparam corr_sample_pkg::prod_t MIN_VAL =
        corr_sample_pkg::prod_t'(UNSIGNED_OUT ? 0 : -(2 ** (`ACC_WIDTH - 1)));

    // arithmetic shift truncates toward minus infinity (floor)
    corr_sample_pkg::prod_t floored;

    assign floored = din >>> SHIFT;

    always_ff @(posedge clk) begin
        if (floored > MAX_VAL) begin
            dout <= corr_sample_pkg::acc_in_t'(MAX_VAL);
        end else if (floored < MIN_VAL) begin
            // unsigned mode clamps at zero here
            dout <= corr_sample_pkg::acc_in_t'(MIN_VAL);
        end else begin
            dout <= corr_sample_pkg::acc_in_t'(floored);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

    // a power arriving negative would vanish in the clamp at zero
    a_unsigned_in: assert property (
        @(posedge clk) disable iff (!rst_n)
        (UNSIGNED_OUT && din_valid) |-> (din >= 0)
    );

endmodule

/* verilog/vector_acc.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

module vector_acc (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      restart,
    input  corr_sample_pkg::acc_in_t  din,
    input  logic                      din_valid,
    output corr_sample_pkg::dout_t    dout,
    output logic                      dout_valid
);

    localparam int LAST_BIN = `VECTOR_LEN - 1;

    // one running sum per bin
    corr_sample_pkg::dout_t sums [`VECTOR_LEN];

    corr_acc_pkg::acc_state_e state;
    corr_acc_pkg::bin_idx_t   bin_idx;

    // restart seen, waiting for the first bin of a frame
    logic pending;
    // first frame after leaving idle overwrites uninitialised sums
    logic fresh;

    logic last_bin;
    logic start;
    logic take;
    logic emit;
    logic replace;
    corr_sample_pkg::dout_t din_ext;

    assign last_bin = (bin_idx == corr_acc_pkg::bin_idx_t'(LAST_BIN));
    // restart may coincide with the first sample of the frame
    assign start    = din_valid && (restart || pending) && (bin_idx == '0);
    assign take     = din_valid && (state != corr_acc_pkg::acc_idle || start);
    // old sums leave only when there was an integration to close
    assign emit     = din_valid && (state == corr_acc_pkg::acc_dump ||
                                    (start && state != corr_acc_pkg::acc_idle));
    assign replace  = start || state == corr_acc_pkg::acc_dump || fresh;
    // signed cast widens with sign extension
    assign din_ext  = corr_sample_pkg::dout_t'(din);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= corr_acc_pkg::acc_idle;
            bin_idx <= '0;
            pending <= 1'b0;
            fresh   <= 1'b0;
        end else begin
            // bins step on valid samples only, gaps just hold position
            if (din_valid) begin
                bin_idx <= last_bin ? '0 : bin_idx + 1'b1;
            end
            if (start) begin
                pending <= 1'b0;
            end else if (restart) begin
                pending <= 1'b1;
            end
            if (start) begin
                if (state == corr_acc_pkg::acc_idle) begin
                    state <= corr_acc_pkg::acc_run;
                    fresh <= !last_bin;
                end else begin
                    state <= last_bin ? corr_acc_pkg::acc_run : corr_acc_pkg::acc_dump;
                end
            end else if (din_valid && last_bin) begin
                fresh <= 1'b0;
                if (state == corr_acc_pkg::acc_dump) begin
                    state <= corr_acc_pkg::acc_run;
                end
            end
        end
    end

    // read of the old sum and write of the new one share the edge
    always_ff @(posedge clk) begin
        if (take) begin
            sums[bin_idx] <= replace ? din_ext : sums[bin_idx] + din_ext;
        end
        if (emit) begin
            dout <= sums[bin_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= emit;
        end
    end

    // new_acc must be placed on a frame boundary
    a_restart_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        restart |-> (bin_idx == '0)
    );

    // a second restart before the first one took effect would be lost
    a_restart_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        restart |-> !pending
    );

endmodule

/* verilog/correlator.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

module correlator (
    input  logic                      clk,
    input  logic                      rst_n,
    // pulse before or with the first sample of a frame
    input  logic                      new_acc,
    input  corr_sample_pkg::sample_t  din1_re,
    input  corr_sample_pkg::sample_t  din1_im,
    input  corr_sample_pkg::sample_t  din2_re,
    input  corr_sample_pkg::sample_t  din2_im,
    input  logic                      din_valid,
    output corr_sample_pkg::dout_t    r11,
    output corr_sample_pkg::dout_t    r22,
    output corr_sample_pkg::dout_t    r12_re,
    output corr_sample_pkg::dout_t    r12_im,
    output logic                      dout_valid
);

    // new_acc has to line up with the samples entering the accumulators
    localparam int RESTART_DLY = `MULT_LAT + `CAST_LAT;

    corr_sample_pkg::prod_t   pow1;
    corr_sample_pkg::prod_t   pow2;
    corr_sample_pkg::prod_t   corr_re;
    corr_sample_pkg::prod_t   corr_im;
    logic                     mult_valid;

    corr_sample_pkg::acc_in_t acc_pow1;
    corr_sample_pkg::acc_in_t acc_pow2;
    corr_sample_pkg::acc_in_t acc_corr_re;
    corr_sample_pkg::acc_in_t acc_corr_im;
    logic                     cast_valid;

    logic [RESTART_DLY-1:0]   new_acc_dly;
    logic                     acc_restart;

    correlation_mults u_mults (
        .clk        (clk),
        .rst_n      (rst_n),
        .din1_re    (din1_re),
        .din1_im    (din1_im),
        .din2_re    (din2_re),
        .din2_im    (din2_im),
        .din_valid  (din_valid),
        .pow1       (pow1),
        .pow2       (pow2),
        .corr_re    (corr_re),
        .corr_im    (corr_im),
        .dout_valid (mult_valid)
    );

    // powers are never negative, clamp at zero
    fixed_cast #(.UNSIGNED_OUT(1'b1)) u_cast_pow1 (
        .clk(clk), .rst_n(rst_n), .din(pow1), .din_valid(mult_valid),
        .dout(acc_pow1), .dout_valid(cast_valid)
    );

    fixed_cast #(.UNSIGNED_OUT(1'b1)) u_cast_pow2 (
        .clk(clk), .rst_n(rst_n), .din(pow2), .din_valid(mult_valid),
        .dout(acc_pow2), .dout_valid()
    );

    // cross terms keep their sign
    fixed_cast #(.UNSIGNED_OUT(1'b0)) u_cast_re (
        .clk(clk), .rst_n(rst_n), .din(corr_re), .din_valid(mult_valid),
        .dout(acc_corr_re), .dout_valid()
    );

    fixed_cast #(.UNSIGNED_OUT(1'b0)) u_cast_im (
        .clk(clk), .rst_n(rst_n), .din(corr_im), .din_valid(mult_valid),
        .dout(acc_corr_im), .dout_valid()
    );

    // shift register, one stage per pipeline cycle ahead of the accumulators
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_acc_dly <= '0;
        end else begin
            new_acc_dly <= {new_acc_dly[RESTART_DLY-2:0], new_acc};
        end
    end

    assign acc_restart = new_acc_dly[RESTART_DLY-1];

    // all four run in lockstep, only the first valid is brought out
    vector_acc u_acc_r11 (
        .clk(clk), .rst_n(rst_n), .restart(acc_restart), .din(acc_pow1),
        .din_valid(cast_valid), .dout(r11), .dout_valid(dout_valid)
    );

    vector_acc u_acc_r22 (
        .clk(clk), .rst_n(rst_n), .restart(acc_restart), .din(acc_pow2),
        .din_valid(cast_valid), .dout(r22), .dout_valid()
    );

    vector_acc u_acc_r12_re (
        .clk(clk), .rst_n(rst_n), .restart(acc_restart), .din(acc_corr_re),
        .din_valid(cast_valid), .dout(r12_re), .dout_valid()
    );

    vector_acc u_acc_r12_im (
        .clk(clk), .rst_n(rst_n), .restart(acc_restart), .din(acc_corr_im),
        .din_valid(cast_valid), .dout(r12_im), .dout_valid()
    );

endmodule

/* tests/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD       = 40.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    // free running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // reset held for a whole number of cycles, released off the edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

/* tests/correlator_tb.sv */
`timescale 1ns/1ps
`include "corr_cfg.svh"

module correlator_tb;

    localparam int N_ROWS = 10;
    localparam int CLK_NS = 40;
    // pipeline depth plus slack before the results of a row are counted
    localparam int DRAIN  = `MULT_LAT + `CAST_LAT + 4;

    // kinds: 0 constant, 1 ramp, 2 random, 3 full scale
    int row_kind    [N_ROWS]    = '{0, 0, 2, 3, 1, 1, 0, 2, 1, 0};
    // din1_re, din1_im, din2_re, din2_im; unused by random and full scale
    int row_val     [N_ROWS][4] = '{
        '{1000, -2000, 3000, 500},
        '{8192, -4096, 12000, -7000},
        '{0, 0, 0, 0},
        '{0, 0, 0, 0},
        '{-1500, 700, 2500, -3300},
        '{-1500, 700, 2500, -3300},
        '{-16384, 5000, 20000, -9000},
        '{0, 0, 0, 0},
        '{300, -300, 900, -900},
        '{1, 2, 3, 4}
    };
    int row_frames  [N_ROWS]    = '{1, 3, 2, 1, 2, 2, 1, 1, 1, 1};
    bit row_gap     [N_ROWS]    = '{0, 0, 0, 0, 0, 1, 0, 0, 0, 0};
    // row 0 has no new_acc, so nothing integrates yet
    bit row_restart [N_ROWS]    = '{0, 1, 1, 1, 1, 1, 1, 1, 1, 1};

    logic                     clk;
    logic                     rst_n;
    logic                     new_acc;
    corr_sample_pkg::sample_t din1_re;
    corr_sample_pkg::sample_t din1_im;
    corr_sample_pkg::sample_t din2_re;
    corr_sample_pkg::sample_t din2_im;
    logic                     din_valid;
    corr_sample_pkg::dout_t   r11;
    corr_sample_pkg::dout_t   r22;
    corr_sample_pkg::dout_t   r12_re;
    corr_sample_pkg::dout_t   r12_im;
    logic                     dout_valid;

    // reference sums per output and bin, wrapping like the DUT width
    int ref_sum [4][`VECTOR_LEN];
    bit integrating;
    // five entries per result: bin, r11, r22, r12_re, r12_im
    int exp_q [$];
    int pushed;
    int got_cnt;
    int extra_cnt;
    int err_cnt;
    int check_cnt;

    clock_gen #(.PERIOD(CLK_NS), .RESET_CYCLES(10)) u_clk (.clk(clk), .rst_n(rst_n));

    correlator dut (
        .clk(clk), .rst_n(rst_n), .new_acc(new_acc),
        .din1_re(din1_re), .din1_im(din1_im), .din2_re(din2_re), .din2_im(din2_im),
        .din_valid(din_valid), .r11(r11), .r22(r22), .r12_re(r12_re), .r12_im(r12_im),
        .dout_valid(dout_valid)
    );

    // floor division by the dropped binary weight
    function automatic longint floor_scale(longint p);
        longint div;
        div = longint'(1) << (2 * `DIN_POINT - `ACC_POINT);
        if (p >= 0) begin
            return p / div;
        end
        return -((-p + div - 1) / div);
    endfunction

    function automatic int to_acc(longint p, bit unsigned_out);
        longint q;
        longint hi;
        longint lo;
        q  = floor_scale(p);
        hi = (longint'(1) << (`ACC_WIDTH - 1)) - 1;
        lo = unsigned_out ? 0 : -(longint'(1) << (`ACC_WIDTH - 1));
        if (q > hi) begin
            q = hi;
        end else if (q < lo) begin
            q = lo;
        end
        return int'(q);
    endfunction

    function automatic int pick_sample(int r, int i, int f, int b);
        corr_sample_pkg::sample_t rnd;
        case (row_kind[r])
            1: pick_sample = row_val[r][i] + 311 * b - 157 * f;
            2: begin
                rnd = corr_sample_pkg::sample_t'($urandom());
                pick_sample = int'(rnd);
            end
            3: pick_sample = -(1 << (`DIN_WIDTH - 1));
            default: pick_sample = row_val[r][i];
        endcase
    endfunction

    task automatic drive(int a, int b, int c, int d, bit valid, bit pulse);
        @(posedge clk);
        #2;
        din1_re   = corr_sample_pkg::sample_t'(a);
        din1_im   = corr_sample_pkg::sample_t'(b);
        din2_re   = corr_sample_pkg::sample_t'(c);
        din2_im   = corr_sample_pkg::sample_t'(d);
        din_valid = valid;
        new_acc   = pulse;
    endtask

    task automatic check_value(string name, int bin, int got, int want);
        check_cnt++;
        if (got != want) begin
            $display("Fail %0t: %s bin %0d got %0d expected %0d", $time, name, bin, got, want);
            err_cnt++;
        end
    endtask

    // one frame of VECTOR_LEN samples, model updated alongside
    task automatic run_frame(int r, int f);
        int     s  [4];
        int     cv [4];
        longint a;
        longint b;
        longint c;
        longint d;
        bit     start;
        bit     was_int;
        start   = row_restart[r] && f == 0;
        was_int = integrating;
        if (start) begin
            integrating = 1'b1;
        end
        for (int bin = 0; bin < `VECTOR_LEN; bin++) begin
            for (int i = 0; i < 4; i++) begin
                s[i] = pick_sample(r, i, f, bin);
            end
            a = s[0];
            b = s[1];
            c = s[2];
            d = s[3];
            // powers clamp at zero, x1 * conj(x2) keeps its sign
            cv[0] = to_acc(a * a + b * b, 1'b1);
            cv[1] = to_acc(c * c + d * d, 1'b1);
            cv[2] = to_acc(a * c + b * d, 1'b0);
            cv[3] = to_acc(b * c - a * d, 1'b0);
            // a restart closes the running integration bin by bin
            if (start && was_int) begin
                exp_q.push_back(bin);
                for (int k = 0; k < 4; k++) begin
                    exp_q.push_back(ref_sum[k][bin]);
                end
                pushed++;
            end
            for (int k = 0; k < 4; k++) begin
                if (start) begin
                    ref_sum[k][bin] = cv[k];
                end else if (was_int) begin
                    ref_sum[k][bin] = ref_sum[k][bin] + cv[k];
                end
            end
            // gap rows idle one cycle ahead of each sample
            // new_acc then rides on that idle cycle, before the first sample
            if (row_gap[r]) begin
                drive(s[0], s[1], s[2], s[3], 1'b0, start && bin == 0);
                drive(s[0], s[1], s[2], s[3], 1'b1, 1'b0);
            end else begin
                drive(s[0], s[1], s[2], s[3], 1'b1, start && bin == 0);
            end
        end
    endtask

    // results sampled mid-cycle, away from the launching edge
    always @(negedge clk) begin : monitor
        int bin;
        if (rst_n && dout_valid) begin
            if (exp_q.size() < 5) begin
                extra_cnt++;
            end else begin
                bin = exp_q.pop_front();
                check_value("r11", bin, int'(r11), exp_q.pop_front());
                check_value("r22", bin, int'(r22), exp_q.pop_front());
                check_value("r12_re", bin, int'(r12_re), exp_q.pop_front());
                check_value("r12_im", bin, int'(r12_im), exp_q.pop_front());
                got_cnt++;
            end
        end
    end

    initial begin : watchdog
        int budget;
        // reset plus margin, then every sample and gap and drain of each row
        budget = 30;
        for (int r = 0; r < N_ROWS; r++) begin
            budget += row_frames[r] * `VECTOR_LEN * (row_gap[r] ? 2 : 1) + 1 + DRAIN;
        end
        #(budget * CLK_NS);
        $display("timeout: the run did not finish within %0d clock cycles", budget);
        $display("Test failed");
        $finish;
    end

    initial begin
        int exp_before;
        int err_before;
        new_acc     = 1'b0;
        din1_re     = '0;
        din1_im     = '0;
        din2_re     = '0;
        din2_im     = '0;
        din_valid   = 1'b0;
        integrating = 1'b0;
        pushed      = 0;
        got_cnt     = 0;
        extra_cnt   = 0;
        err_cnt     = 0;
        check_cnt   = 0;
        void'($urandom(91058));
        @(posedge rst_n);
        for (int r = 0; r < N_ROWS; r++) begin
            got_cnt    = 0;
            extra_cnt  = 0;
            exp_before = pushed;
            err_before = err_cnt;
            for (int f = 0; f < row_frames[r]; f++) begin
                run_frame(r, f);
            end
            drive(0, 0, 0, 0, 1'b0, 1'b0);
            repeat (DRAIN) @(posedge clk);
            if (got_cnt < pushed - exp_before) begin
                $display("test %0d: only %0d of %0d results came out of the DUT",
                         r, got_cnt, pushed - exp_before);
                err_cnt++;
                exp_q.delete();
            end
            if (extra_cnt > 0) begin
                $display("test %0d: DUT gave %0d results that were not due", r, extra_cnt);
                err_cnt++;
            end
            $display("test %0d kind %0d: %0d results, %0d errors",
                     r, row_kind[r], got_cnt, err_cnt - err_before);
        end
        $display("tests %0d, checks %0d, errors %0d", N_ROWS, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
verilog/corr_sample_pkg.sv
verilog/corr_acc_pkg.sv
verilog/correlation_mults.sv
verilog/fixed_cast.sv
verilog/vector_acc.sv
verilog/correlator.sv
tests/clock_gen.sv
tests/correlator_tb.sv
